// File: all.f
eeprom_cmd_pkg.sv
i2c_bus_pkg.sv
i2c_bit_engine.sv
eeprom_seq.sv
eeprom_ctrl_top.sv
tb_clock_gen.sv
eeprom_model.sv
tb_checker.sv
tb_top.sv

// File: eeprom_cmd_pkg.sv
package eeprom_cmd_pkg;

    localparam int ADDR_W = 11;   // 2 KB array
    localparam int DATA_W = 8;

    typedef enum logic
    {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } eeprom_op_e;

    // host request, held stable while req is high
    typedef struct packed
    {
        eeprom_op_e          op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
    } eeprom_req_t;

    typedef struct packed
    {
        logic [DATA_W-1:0]   rdata;   // valid with ack on a read
    } eeprom_rsp_t;

endpackage

// File: eeprom_ctrl_top.sv
`timescale 1ns/1ns
module eeprom_ctrl_top
(
    input  logic                        CLK,
    input  logic                        RESET,
    input  logic                        req,
    input  eeprom_cmd_pkg::eeprom_req_t req_data,
    output logic                        ack,
    output eeprom_cmd_pkg::eeprom_rsp_t rsp_data,
    output logic                        scl,
    output logic                        sda_low,
    input  logic                        sda_in
);
    import i2c_bus_pkg::*;

    logic        go;
    bit_cmd_t    cmd;
    logic        done;
    logic [7:0]  rx_byte;

    // transaction sequencer
    eeprom_seq u_seq
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp_data (rsp_data),
        .go       (go),
        .cmd      (cmd),
        .done     (done),
        .rx_byte  (rx_byte)
    );

    i2c_bit_engine u_engine
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .go       (go),
        .cmd      (cmd),
        .done     (done),
        .rx_byte  (rx_byte),
        .scl      (scl),
        .sda_low  (sda_low),
        .sda_in   (sda_in)   // resolved line
    );

endmodule

// File: eeprom_model.sv
`timescale 1ns/1ns
module eeprom_model
(
    input  logic CLK,
    input  logic scl,
    input  logic sda,       // resolved line
    output logic sda_low
);
    import eeprom_cmd_pkg::*;
    import i2c_bus_pkg::*;

    typedef enum logic [2:0]
    {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_RDATA
    } model_state_e;

    logic [DATA_W-1:0]  mem [0:(1<<ADDR_W)-1];
    model_state_e       state;
    model_state_e       nxt;    // state after the ack clock
    logic [ADDR_W-1:0]  ptr;
    logic [7:0]         shift;
    logic [3:0]         bit_cnt;
    logic               in_ack;
    logic               scl_q;
    logic               sda_q;

    // block bits folded in so every 256 byte block differs
    function automatic logic [DATA_W-1:0] fill_byte(input logic [ADDR_W-1:0] a);
        return a[7:0] ^ 8'h5A ^ {5'b0, ~a[10:8]};
    endfunction

    initial
    begin
        for (int i = 0; i < (1<<ADDR_W); i++)
            mem[i] <= fill_byte(ADDR_W'(i));
        state   <= M_IDLE;
        nxt     <= M_IDLE;
        sda_low <= 1'b0;
        in_ack  <= 1'b0;
        bit_cnt <= 4'd0;
        scl_q   <= 1'b1;
        sda_q   <= 1'b1;
    end

    // lines oversampled on CLK, edges found against the last sample
    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (scl_q && scl && sda_q && !sda)   // start or repeated start
        begin
            state   <= M_CTRL;
            bit_cnt <= 4'd0;
            in_ack  <= 1'b0;
            sda_low <= 1'b0;
        end
        else if (scl_q && scl && !sda_q && sda)   // stop
        begin
            state   <= M_IDLE;
            sda_low <= 1'b0;
        end
        else if (!scl_q && scl && state != M_IDLE)
        begin
            if (bit_cnt < 4'd8)
            begin
                if (state != M_RDATA)
                    shift <= {shift[6:0], sda};
                bit_cnt <= bit_cnt + 4'd1;
            end
            else if (state == M_RDATA)
                state <= M_IDLE;   // master nack on the ninth clock
        end
        else if (scl_q && !scl && state != M_IDLE)
        begin
            if (state == M_RDATA)
            begin
                if (bit_cnt < 4'd8)
                begin
                    sda_low <= ~shift[6];
                    shift   <= {shift[6:0], 1'b0};
                end
                else
                    sda_low <= 1'b0;
            end
            else if (in_ack)
            begin
                in_ack  <= 1'b0;
                bit_cnt <= 4'd0;
                state   <= nxt;
                sda_low <= 1'b0;
                if (nxt == M_RDATA)
                begin
                    shift   <= mem[ptr];
                    sda_low <= ~mem[ptr][7];   // msb goes out right away
                end
            end
            else if (bit_cnt == 4'd8)
            begin
                in_ack  <= 1'b1;
                sda_low <= 1'b1;
                case (state)
                    M_CTRL:
                    begin
                        ptr[10:8] <= shift[3:1];
                        if (shift[7:4] != DEV_CODE)
                            nxt <= M_IDLE;
                        else if (shift[0])
                            nxt <= M_RDATA;
                        else
                            nxt <= M_ADDR;
                    end
                    M_ADDR:
                    begin
                        ptr[7:0] <= shift;
                        nxt      <= M_WDATA;
                    end
                    default:
                    begin
                        mem[ptr] <= shift;
                        ptr      <= ptr + 11'd1;
                        nxt      <= M_WDATA;
                    end
                endcase
            end
        end
    end

endmodule

// File: eeprom_seq.sv
`timescale 1ns/1ns
module eeprom_seq
(
    input  logic                        CLK,
    input  logic                        RESET,
    input  logic                        req,
    input  eeprom_cmd_pkg::eeprom_req_t req_data,
    output logic                        ack,
    output eeprom_cmd_pkg::eeprom_rsp_t rsp_data,
    output logic                        go,
    output i2c_bus_pkg::bit_cmd_t       cmd,
    input  logic                        done,
    input  logic [7:0]                  rx_byte
);
    import eeprom_cmd_pkg::*;
    import i2c_bus_pkg::*;

    typedef enum logic [3:0]
    {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA_W,
        S_RSTART,
        S_CTRL_R,
        S_DATA_R,
        S_STOP,
        S_ACK
    } seq_state_e;

    seq_state_e   state;
    eeprom_req_t  req_q;
    logic         start_req;

    assign start_req = (state == S_IDLE) && req && !ack;

    // command follows the state, engine latches it with go
    always_comb
    begin
        cmd.op   = BIT_STOP;
        cmd.data = 8'h00;
        case (state)
            S_START, S_RSTART:
                cmd.op = BIT_START;
            S_CTRL_W:
            begin
                cmd.op   = BIT_WRITE;
                cmd.data = {DEV_CODE, req_q.addr[ADDR_W-1:8], 1'b0};
            end
            S_ADDR:
            begin
                cmd.op   = BIT_WRITE;
                cmd.data = req_q.addr[7:0];
            end
            S_DATA_W:
            begin
                cmd.op   = BIT_WRITE;
                cmd.data = req_q.wdata;
            end
            S_CTRL_R:
            begin
                cmd.op   = BIT_WRITE;
                cmd.data = {DEV_CODE, req_q.addr[ADDR_W-1:8], 1'b1};
            end
            S_DATA_R:
                cmd.op = BIT_READ;
            default:
                cmd.op = BIT_STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= S_IDLE;
            go    <= 1'b0;
            ack   <= 1'b0;
        end
        else
        begin
            go <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (start_req)
                    begin
                        state <= S_START;
                        go    <= 1'b1;
                    end
                end
                S_STOP:
                begin
                    if (done)
                    begin
                        state <= S_ACK;
                        ack   <= 1'b1;   // stop is on the bus now
                    end
                end
                S_ACK:
                begin
                    if (!req)
                    begin
                        state <= S_IDLE;
                        ack   <= 1'b0;
                    end
                end
                default:
                begin
                    if (done)
                    begin
                        go <= 1'b1;
                        case (state)
                            S_START:  state <= S_CTRL_W;
                            S_CTRL_W: state <= S_ADDR;
                            S_ADDR:   state <= (req_q.op == OP_WRITE) ? S_DATA_W : S_RSTART;
                            S_RSTART: state <= S_CTRL_R;
                            S_CTRL_R: state <= S_DATA_R;
                            default:  state <= S_STOP;   // after data write or read
                        endcase
                    end
                end
            endcase
        end
    end

    // request and read data capture
    always_ff @(posedge CLK)
    begin
        if (start_req)
        begin
            req_q <= req_data;
        end
        if (state == S_DATA_R && done)
        begin
            rsp_data.rdata <= rx_byte;
        end
    end

endmodule

// File: i2c_bit_engine.sv
`timescale 1ns/1ns
module i2c_bit_engine
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   go,
    input  i2c_bus_pkg::bit_cmd_t  cmd,
    output logic                   done,
    output logic [7:0]             rx_byte,
    output logic                   scl,
    output logic                   sda_low,
    input  logic                   sda_in
);
    import i2c_bus_pkg::*;

    typedef logic [$clog2(2*SCL_HALF)-1:0] phase_t;

    logic        busy;
    phase_t      phase_cnt;     // position inside one bit slot
    logic [3:0]  bit_cnt;       // 0..8 for byte ops
    bit_op_e     cur_op;
    logic [7:0]  tx_shift;

    logic        accept;
    logic        q0;
    logic        q1;
    logic        q2;
    logic        q3;
    logic        last_cyc;
    logic        ninth_bit;

    assign accept    = go && !busy;
    assign q0        = (phase_cnt == phase_t'(0));
    assign q1        = (phase_cnt == phase_t'(SCL_HALF/2));
    assign q2        = (phase_cnt == phase_t'(SCL_HALF));    // middle of SCL high
    assign q3        = (phase_cnt == phase_t'(3*SCL_HALF/2));
    assign last_cyc  = (phase_cnt == phase_t'(2*SCL_HALF-1));
    assign ninth_bit = (bit_cnt == 4'd8);

    // control and line drivers
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy      <= 1'b0;
            done      <= 1'b0;
            phase_cnt <= '0;
            bit_cnt   <= '0;
            scl       <= 1'b1;   // idle bus
            sda_low   <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (!busy)
            begin
                if (go)
                begin
                    busy      <= 1'b1;
                    phase_cnt <= '0;
                    bit_cnt   <= '0;
                end
            end
            else
            begin
                case (cur_op)
                    BIT_START:
                    begin
                        if (q0) sda_low <= 1'b0;
                        if (q1) scl <= 1'b1;
                        if (q2) sda_low <= 1'b1;   // falling SDA with SCL high
                        if (q3) scl <= 1'b0;
                    end
                    BIT_STOP:
                    begin
                        if (q0) sda_low <= 1'b1;
                        if (q1) scl <= 1'b1;
                        if (q2) sda_low <= 1'b0;   // rising SDA with SCL high
                    end
                    BIT_WRITE:
                    begin
                        if (q0) sda_low <= ninth_bit ? 1'b0 : ~tx_shift[7];
                        if (q1) scl <= 1'b1;
                        if (q3) scl <= 1'b0;
                    end
                    default:
                    begin
                        if (q0) sda_low <= 1'b0;   // released, ninth bit is the nack
                        if (q1) scl <= 1'b1;
                        if (q3) scl <= 1'b0;
                    end
                endcase

                if (last_cyc)
                begin
                    phase_cnt <= '0;
                    if ((cur_op == BIT_WRITE || cur_op == BIT_READ) && !ninth_bit)
                    begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                    else
                    begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                end
                else
                begin
                    phase_cnt <= phase_cnt + phase_t'(1);
                end
            end
        end
    end

    // shift registers
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            cur_op   <= cmd.op;
            tx_shift <= cmd.data;
        end
        else if (busy)
        begin
            if (cur_op == BIT_WRITE && q3)
            begin
                tx_shift <= {tx_shift[6:0], 1'b0};   // msb first
            end
            if (cur_op == BIT_READ && q2 && !ninth_bit)
            begin
                rx_byte <= {rx_byte[6:0], sda_in};
            end
        end
    end

endmodule

// File: i2c_bus_pkg.sv
package i2c_bus_pkg;

    // device type code, upper nibble of the control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // CLK cycles per SCL half period, keep it even
    localparam int SCL_HALF = 4;

    // bit engine operations
    // a repeated start is a plain start issued with SCL low after a byte
    typedef enum logic [1:0]
    {
        BIT_START = 2'd0,
        BIT_STOP  = 2'd1,
        BIT_WRITE = 2'd2,   // 8 bits out, ninth clock released
        BIT_READ  = 2'd3    // 8 bits in, ninth clock is master nack
    } bit_op_e;

    typedef struct packed
    {
        bit_op_e      op;
        logic [7:0]   data;   // only used by BIT_WRITE
    } bit_cmd_t;

endpackage

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns -f all.f --top-module tb_top -o tb_sim \
    > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb_checker.sv
`timescale 1ns/1ns
module tb_checker
(
    input  logic                        CLK,
    input  logic                        RESET,
    input  logic                        idle_check,
    input  logic                        req,
    input  eeprom_cmd_pkg::eeprom_req_t req_data,
    input  logic                        ack,
    input  eeprom_cmd_pkg::eeprom_rsp_t rsp_data,
    input  logic                        scl,
    input  logic                        sda_low,
    output int                          err_count,
    output int                          check_count
);
    import eeprom_cmd_pkg::*;

    logic [DATA_W-1:0]  mirror  [0:(1<<ADDR_W)-1];
    logic               written [0:(1<<ADDR_W)-1];
    logic               ack_q;
    logic               req_q;

    // last written value, or the power-up pattern of the slave array
    function automatic logic [DATA_W-1:0] expected_byte(input logic [ADDR_W-1:0] addr);
        if (written[addr])
            return mirror[addr];
        return addr[7:0] ^ 8'h5A ^ {5'b0, ~addr[10:8]};
    endfunction

    initial
    begin
        for (int i = 0; i < (1<<ADDR_W); i++)
            written[i] <= 1'b0;
        err_count   <= 0;
        check_count <= 0;
        ack_q       <= 1'b0;
        req_q       <= 1'b0;
    end

    always @(posedge CLK)
    begin
        int                 errs;
        logic [DATA_W-1:0]  exp_byte;
        errs  = 0;
        ack_q <= ack;
        req_q <= req;
        if (!RESET)
        begin
            if (idle_check && (scl !== 1'b1 || sda_low !== 1'b0 || ack !== 1'b0))
            begin
                $display("%0t: bus or handshake not idle after reset (scl=%b sda_low=%b ack=%b)",
                         $time, scl, sda_low, ack);
                errs++;
            end
            if (ack && !ack_q)
            begin
                if (!req)
                begin
                    $display("%0t: ack rose while req was low", $time);
                    errs++;
                end
                if (req_data.op == OP_WRITE)
                begin
                    mirror[req_data.addr]  <= req_data.wdata;
                    written[req_data.addr] <= 1'b1;
                end
                else
                begin
                    exp_byte = expected_byte(req_data.addr);
                    check_count <= check_count + 1;
                    if (rsp_data.rdata !== exp_byte)
                    begin
                        $display("[FAIL] %0t rsp_data.rdata addr 0x%03h: expected 0x%02h got 0x%02h",
                                 $time, req_data.addr, exp_byte, rsp_data.rdata);
                        errs++;
                    end
                end
            end
            if (!ack && ack_q && req_q)
            begin
                $display("%0t: ack fell while req was still high", $time);
                errs++;
            end
            if (ack && !req && !req_q)
            begin
                $display("%0t: ack still high more than a cycle after req fell", $time);
                errs++;
            end
            if (ack && req && scl !== 1'b1)
            begin
                $display("%0t: scl left idle while ack was high and req held", $time);
                errs++;
            end
        end
        err_count <= err_count + errs;
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ns
module tb_clock_gen
(
    output logic CLK,
    output logic RESET
);
    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;   // 10 ns period
    end

    initial
    begin
        RESET <= 1'b1;
        repeat (2) @(posedge CLK);
        RESET <= 1'b0;
    end

endmodule

// File: tb_top.sv
`timescale 1ns/1ns
module tb_top;
    import eeprom_cmd_pkg::*;
    import i2c_bus_pkg::*;

    localparam int N_TXN      = 48;
    localparam int TXN_CYCLES = 90*SCL_HALF + 40;   // a read is 78 half periods plus hold
    localparam int LIMIT_NS   = N_TXN * TXN_CYCLES * 10 + 2000;

    logic         CLK;
    logic         RESET;
    logic         req;
    eeprom_req_t  req_data;
    logic         ack;
    eeprom_rsp_t  rsp_data;
    logic         scl;
    logic         uut_sda_low;
    logic         model_sda_low;
    logic         sda;
    logic         idle_check;
    int           err_count;
    int           check_count;
    int           seed;
    int           reads_issued;
    int           test_num;

    assign sda = ~(uut_sda_low | model_sda_low);   // pulled up, either side pulls low

    tb_clock_gen clk_gen
    (
        .CLK   (CLK),
        .RESET (RESET)
    );

    eeprom_ctrl_top UUT
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp_data (rsp_data),
        .scl      (scl),
        .sda_low  (uut_sda_low),
        .sda_in   (sda)
    );

    eeprom_model slave
    (
        .CLK     (CLK),
        .scl     (scl),
        .sda     (sda),
        .sda_low (model_sda_low)
    );

    tb_checker chk
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .idle_check  (idle_check),
        .req         (req),
        .req_data    (req_data),
        .ack         (ack),
        .rsp_data    (rsp_data),
        .scl         (scl),
        .sda_low     (uut_sda_low),
        .err_count   (err_count),
        .check_count (check_count)
    );

    // one four-phase transaction, req held for hold cycles after ack
    task automatic run_txn
    (
        input eeprom_op_e         op,
        input logic [ADDR_W-1:0]  addr,
        input logic [DATA_W-1:0]  wdata,
        input int                 hold
    );
        @(posedge CLK);
        req_data.op    <= op;
        req_data.addr  <= addr;
        req_data.wdata <= wdata;
        req            <= 1'b1;
        do
            @(posedge CLK);
        while (!ack);
        repeat (hold) @(posedge CLK);
        req <= 1'b0;
        do
            @(posedge CLK);
        while (ack);
        @(posedge CLK);   // checker count from the last edge lands here
        if (op == OP_READ)
            reads_issued++;
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_num++;
        if (err_count == errs_before)
            $display("test %0d %s: ok", test_num, name);
        else
            $display("test %0d %s: %0d errors", test_num, name, err_count - errs_before);
    endtask

    initial
    begin
        logic [31:0]        rnd;
        logic [ADDR_W-1:0]  addr;
        logic [ADDR_W-1:0]  last_waddr;
        eeprom_op_e         op;
        int                 errs_before;
        int                 fails;
        seed         = 23;
        reads_issued = 0;
        test_num     = 0;
        last_waddr   = 11'h123;
        req        <= 1'b0;
        req_data   <= '0;
        idle_check <= 1'b0;
        wait (RESET == 1'b0);
        @(posedge CLK);

        errs_before = err_count;
        idle_check <= 1'b1;
        repeat (20) @(posedge CLK);
        idle_check <= 1'b0;
        @(posedge CLK);
        report_test("idle bus after reset", errs_before);

        errs_before = err_count;
        run_txn(OP_WRITE, 11'h123, 8'h3C, 0);
        run_txn(OP_READ, 11'h123, 8'h00, 0);
        run_txn(OP_READ, 11'h023, 8'h00, 0);   // same low byte, other block
        report_test("write then read of 0x123", errs_before);

        errs_before = err_count;
        run_txn(OP_READ, 11'h7FF, 8'h00, 0);
        report_test("read of unwritten 0x7ff", errs_before);

        errs_before = err_count;
        for (int i = 0; i < 40; i++)
        begin
            rnd  = $random(seed);
            addr = ADDR_W'($random(seed));
            if (rnd[0])
            begin
                op = OP_READ;
                if (rnd[1])
                    addr = last_waddr;   // hit a byte that was just written
            end
            else
            begin
                op         = OP_WRITE;
                last_waddr = addr;
            end
            run_txn(op, addr, rnd[15:8], int'(rnd[19:16]));
        end
        report_test("random mix of 40", errs_before);

        errs_before = err_count;
        run_txn(OP_WRITE, 11'h2A5, 8'hC3, 0);
        run_txn(OP_READ, 11'h2A5, 8'h00, 15);
        run_txn(OP_WRITE, 11'h05A, 8'h81, 15);
        run_txn(OP_READ, 11'h05A, 8'h00, 0);
        report_test("handshake holds", errs_before);

        fails = err_count;
        if (check_count != reads_issued)
        begin
            $display("checker compared %0d reads but %0d were issued", check_count, reads_issued);
            fails = fails + 1;
        end
        $display("%0d tests, %0d reads checked, %0d errors", test_num, check_count, fails);
        if (fails == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        #(LIMIT_NS);
        $display("watchdog timeout, the transactions did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
